//--- common/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////
// Word and line
////////////////////

`define WORD_BITS      32
`define BYTES_PER_WORD 4    // One enable per byte
`define LINE_WORDS     8    // Also the burst length
`define BEAT_BITS      3

////////////////////
// Sizes
////////////////////

`define CACHE_LINES    4
`define INDEX_BITS     2
`define RAM_WORDS      256
`define ADDR_BITS      8    // Word address

// What is left of the address above index and beat
`define TAG_BITS       (`ADDR_BITS - `INDEX_BITS - `BEAT_BITS)

`endif

//--- common/mem_pkg.sv
`include "cache_settings.svh"

package mem_pkg;

    ////////////////////
    // Data path types
    ////////////////////

    // One data word
    typedef logic [`WORD_BITS-1:0] word_t;

    // Word address into the backing RAM
    typedef logic [`ADDR_BITS-1:0] addr_t;

    typedef logic [`BYTES_PER_WORD-1:0] ben_t;  // Byte enables

    // Word within a line
    typedef logic [`BEAT_BITS-1:0] beat_t;

endpackage

//--- common/cache_pkg.sv
package cache_pkg;

    ////////////////////
    // Controller
    ////////////////////

    // Miss handling states, the _D kinds write the victim back first
    typedef enum logic [2:0] {
        NORMAL,
        IC_MISS,
        DC_MISS,
        DC_MISS_D,
        DOUBLE_MISS,
        DOUBLE_MISS_D
    } ctrl_state_t;

    // RAM address source
    typedef enum logic [1:0] {
        RAM_SRC_IC,       // Instruction line
        RAM_SRC_DC,       // Data line
        RAM_SRC_VICTIM    // Dirty line leaving the data cache
    } ram_src_t;

endpackage

//--- cache/cache_array.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_array
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  addr_t                addr,
    input  logic                 wr,
    input  logic                 set_valid,
    input  logic                 set_dirty,
    input  word_t                wr_data,
    input  ben_t                 wr_ben,
    output logic                 hit,
    output logic                 dirty,
    output logic [`TAG_BITS-1:0] victim_tag,
    output word_t                rdata
);

    logic [`TAG_BITS-1:0]   tag;
    logic [`INDEX_BITS-1:0] index;
    beat_t                  beat;
    logic                   fill_done;

    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;
    logic [`TAG_BITS-1:0]    tag_q  [`CACHE_LINES];
    word_t                   data_q [`CACHE_LINES][`LINE_WORDS];

    assign {tag, index, beat} = addr;

    ////////////////////
    // Lookup
    ////////////////////

    assign hit        = valid_q[index] && (tag_q[index] == tag);
    assign dirty      = valid_q[index] && dirty_q[index];
    assign victim_tag = tag_q[index];          // Tag of whatever sits at this index
    assign rdata      = data_q[index][beat];

    // Last word of a fill makes the line live
    assign fill_done = wr && set_valid && (beat == beat_t'(`LINE_WORDS - 1));

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_done) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            for (int b = 0; b < `BYTES_PER_WORD; b++) begin
                if (wr_ben[b]) begin
                    data_q[index][beat][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        if (fill_done) begin
            tag_q[index]   <= tag;
            dirty_q[index] <= 1'b0;   // Fresh copy of RAM
        end else if (set_dirty) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // Dirty marking comes only with a processor store from the controller
    a_dirty_needs_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        set_dirty |-> wr
    ) else $error("set_dirty without a write");

endmodule

//--- cache/cache_control.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_control
    import mem_pkg::*;
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    // Processor ports
    input  logic                 ic_req,
    input  addr_t                ic_addr,
    input  logic                 dc_req,
    input  logic                 dc_we,
    input  addr_t                dc_addr,
    input  word_t                dc_wdata,
    input  ben_t                 dc_ben,
    output logic                 ic_ack,
    output logic                 dc_ack,
    // Array status
    input  logic                 ic_hit,
    input  logic                 dc_hit,
    input  logic                 dc_dirty,
    input  logic [`TAG_BITS-1:0] dc_victim_tag,
    input  word_t                dc_word,
    // Array control
    output addr_t                ic_lookup_addr,
    output logic                 ic_fill,
    output word_t                ic_fill_data,
    output addr_t                dc_lookup_addr,
    output logic                 dc_wr,
    output word_t                dc_wr_data,
    output ben_t                 dc_wr_ben,
    output logic                 dc_set_valid,
    output logic                 dc_set_dirty,
    // Backing RAM
    output addr_t                ram_addr,
    output logic                 ram_en,
    output logic                 ram_we,
    input  word_t                ram_rdata
);

    localparam int LINE_BITS = `ADDR_BITS - `BEAT_BITS;
    localparam logic [`BEAT_BITS:0] LAST_CNT = `LINE_WORDS;

    ctrl_state_t state, state_next;
    ram_src_t    ram_src;

    logic [`BEAT_BITS:0]    cnt;         // Runs one past the last beat for RAM latency
    logic                   last;
    beat_t                  cnt_beat;
    beat_t                  fill_beat;
    logic                   fill_wr;
    logic [LINE_BITS-1:0]   ic_line;
    logic [LINE_BITS-1:0]   dc_line;
    logic [`INDEX_BITS-1:0] dc_index;
    addr_t                  ic_fill_addr;

    logic normal;
    logic ic_pend, dc_pend;
    logic dc_wr_hit, ic_take, dc_take;
    logic ic_miss, dc_miss;

    assign last      = (cnt == LAST_CNT);
    assign cnt_beat  = cnt[`BEAT_BITS-1:0];
    assign fill_beat = cnt_beat - 1'b1;   // RAM word arrives a cycle late
    assign fill_wr   = (cnt != '0);

    assign ic_line      = ic_addr[`ADDR_BITS-1:`BEAT_BITS];
    assign dc_line      = dc_addr[`ADDR_BITS-1:`BEAT_BITS];
    assign dc_index     = dc_addr[`BEAT_BITS +: `INDEX_BITS];
    assign ic_fill_addr = {ic_line, fill_beat};

    ////////////////////
    // Lookup decisions for NORMAL
    ////////////////////

    assign normal  = (state == NORMAL);
    assign ic_pend = ic_req && !ic_ack;
    assign dc_pend = dc_req && !dc_ack;

    // Store hit also patches the ic copy and needs the ic lookup free of a held ack
    assign dc_wr_hit = normal && dc_pend && dc_we && dc_hit && !ic_ack;
    assign ic_take   = normal && ic_pend && ic_hit && !dc_wr_hit;
    assign dc_take   = dc_wr_hit || (normal && dc_pend && !dc_we && dc_hit);
    assign ic_miss   = ic_pend && !ic_hit && !dc_wr_hit;
    assign dc_miss   = dc_pend && !dc_hit;

    always_comb begin
        state_next = state;
        case (state)
            NORMAL: begin
                if (dc_miss && ic_miss) begin
                    state_next = dc_dirty ? DOUBLE_MISS_D : DOUBLE_MISS;
                end else if (dc_miss) begin
                    state_next = dc_dirty ? DC_MISS_D : DC_MISS;
                end else if (ic_miss && !dc_pend && !dc_ack) begin
                    state_next = IC_MISS;   // Coherence check borrows the dc lookup
                end
            end
            IC_MISS:       if (last) state_next = NORMAL;
            DOUBLE_MISS:   if (last) state_next = DC_MISS;
            DC_MISS:       if (last) state_next = NORMAL;
            DC_MISS_D:     if (last) state_next = DC_MISS;
            DOUBLE_MISS_D: if (last) state_next = DOUBLE_MISS;
            default:       state_next = NORMAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= NORMAL;
            cnt    <= '0;
            ic_ack <= 1'b0;
            dc_ack <= 1'b0;
        end else begin
            state <= state_next;
            cnt   <= (normal || last) ? '0 : cnt + 1'b1;
            ic_ack <= ic_ack ? ic_req : ic_take;   // Held until req drops
            dc_ack <= dc_ack ? dc_req : dc_take;
        end
    end

    ////////////////////
    // Array and RAM steering
    ////////////////////

    always_comb begin
        ic_lookup_addr = ic_addr;
        dc_lookup_addr = dc_addr;
        ic_fill        = 1'b0;
        ic_fill_data   = ram_rdata;
        dc_wr          = 1'b0;
        dc_wr_data     = ram_rdata;
        dc_wr_ben      = '1;
        dc_set_valid   = 1'b0;
        dc_set_dirty   = 1'b0;
        ram_src        = RAM_SRC_IC;
        ram_en         = 1'b0;
        ram_we         = 1'b0;
        case (state)
            NORMAL: begin
                if (dc_wr_hit) begin
                    ic_lookup_addr = dc_addr;
                end
                ic_fill      = dc_wr_hit && ic_hit;
                ic_fill_data = dc_wdata;
                dc_wr        = dc_wr_hit;
                dc_wr_data   = dc_wdata;
                dc_wr_ben    = dc_ben;
                dc_set_dirty = dc_wr_hit;
            end
            IC_MISS, DOUBLE_MISS: begin
                ic_lookup_addr = ic_fill_addr;
                dc_lookup_addr = ic_fill_addr;
                ic_fill        = fill_wr;
                if (dc_hit) begin
                    ic_fill_data = dc_word;   // Newer copy in data cache
                end else begin
                    ram_en = !last;
                end
            end
            DC_MISS: begin
                dc_lookup_addr = {dc_line, fill_beat};
                dc_wr          = fill_wr;
                dc_set_valid   = fill_wr;
                ram_src        = RAM_SRC_DC;
                ram_en         = !last;
            end
            DC_MISS_D, DOUBLE_MISS_D: begin
                dc_lookup_addr = {dc_line, cnt_beat};   // Victim read straight to RAM
                ram_src        = RAM_SRC_VICTIM;
                ram_en         = !last;
                ram_we         = !last;
            end
            default: begin
                ram_en = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (ram_src)
            RAM_SRC_IC: ram_addr = {ic_line, cnt_beat};
            RAM_SRC_DC: ram_addr = {dc_line, cnt_beat};
            default:    ram_addr = {dc_victim_tag, dc_index, cnt_beat};
        endcase
    end

    // The victim line stays valid and dirty until its refill
    a_we_only_writeback: assert property (
        @(posedge clk) disable iff (!rst_n)
        ram_we |-> ((state inside {DC_MISS_D, DOUBLE_MISS_D}) && dc_dirty)
    ) else $error("RAM write outside a dirty write-back");

    a_ack_from_normal: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($rose(ic_ack) || $rose(dc_ack)) |-> ($past(state) == NORMAL)
    ) else $error("ack raised during miss handling");

    // Array contents under a held ack stay put
    a_no_fill_under_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ic_ack && ic_fill)
    ) else $error("ic fill while ic_ack high");

endmodule

//--- design/line_ram.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module line_ram
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  en,
    input  logic  we,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata
);

    ////////////////////
    // Backing store
    ////////////////////

    word_t mem [`RAM_WORDS];

    // One port, read data a cycle after the address
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;      // Whole word only
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_top
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    // Instruction port
    input  logic  ic_req,
    input  addr_t ic_addr,
    output logic  ic_ack,
    output word_t ic_rdata,
    // Data port
    input  logic  dc_req,
    input  logic  dc_we,
    input  addr_t dc_addr,
    input  word_t dc_wdata,
    input  ben_t  dc_ben,
    output logic  dc_ack,
    output word_t dc_rdata
);

    logic                 ic_hit, dc_hit, dc_dirty;
    logic [`TAG_BITS-1:0] dc_victim_tag;
    addr_t                ic_lookup_addr, dc_lookup_addr;
    logic                 ic_fill;
    word_t                ic_fill_data;
    logic                 dc_wr, dc_set_valid, dc_set_dirty;
    word_t                dc_wr_data;
    ben_t                 dc_wr_ben;
    addr_t                ram_addr;
    logic                 ram_en, ram_we;
    word_t                ram_rdata;

    ////////////////////
    // Controller
    ////////////////////

    cache_control control (
        .clk            (clk),
        .rst_n          (rst_n),
        .ic_req         (ic_req),
        .ic_addr        (ic_addr),
        .dc_req         (dc_req),
        .dc_we          (dc_we),
        .dc_addr        (dc_addr),
        .dc_wdata       (dc_wdata),
        .dc_ben         (dc_ben),
        .ic_ack         (ic_ack),
        .dc_ack         (dc_ack),
        .ic_hit         (ic_hit),
        .dc_hit         (dc_hit),
        .dc_dirty       (dc_dirty),
        .dc_victim_tag  (dc_victim_tag),
        .dc_word        (dc_rdata),
        .ic_lookup_addr (ic_lookup_addr),
        .ic_fill        (ic_fill),
        .ic_fill_data   (ic_fill_data),
        .dc_lookup_addr (dc_lookup_addr),
        .dc_wr          (dc_wr),
        .dc_wr_data     (dc_wr_data),
        .dc_wr_ben      (dc_wr_ben),
        .dc_set_valid   (dc_set_valid),
        .dc_set_dirty   (dc_set_dirty),
        .ram_addr       (ram_addr),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_rdata      (ram_rdata)
    );

    ////////////////////
    // Arrays and RAM
    ////////////////////

    // Every ic write is a fill or a store patch, never dirty
    cache_array ic_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (ic_lookup_addr),
        .wr         (ic_fill),
        .set_valid  (ic_fill),
        .set_dirty  (1'b0),
        .wr_data    (ic_fill_data),
        .wr_ben     (dc_wr_ben),
        .hit        (ic_hit),
        .dirty      (),
        .victim_tag (),
        .rdata      (ic_rdata)
    );

    cache_array dc_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (dc_lookup_addr),
        .wr         (dc_wr),
        .set_valid  (dc_set_valid),
        .set_dirty  (dc_set_dirty),
        .wr_data    (dc_wr_data),
        .wr_ben     (dc_wr_ben),
        .hit        (dc_hit),
        .dirty      (dc_dirty),
        .victim_tag (dc_victim_tag),
        .rdata      (dc_rdata)
    );

    line_ram ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (dc_rdata),   // Write-back data straight from the dc read port
        .rdata (ram_rdata)
    );

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 5;    // 10 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- dv/tb_cache.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module tb_cache
    import mem_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int MIX_ACCESSES   = 2000;

    logic  clk, rst_n;
    logic  ic_req, ic_ack;
    addr_t ic_addr;
    word_t ic_rdata;
    logic  dc_req, dc_we, dc_ack;
    addr_t dc_addr;
    word_t dc_wdata, dc_rdata;
    ben_t  dc_ben;

    word_t model [`RAM_WORDS];   // Flat view of memory as the processor sees it

    clk_gen clocks (.clk(clk), .rst_n(rst_n));

    cache_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .ic_req   (ic_req),
        .ic_addr  (ic_addr),
        .ic_ack   (ic_ack),
        .ic_rdata (ic_rdata),
        .dc_req   (dc_req),
        .dc_we    (dc_we),
        .dc_addr  (dc_addr),
        .dc_wdata (dc_wdata),
        .dc_ben   (dc_ben),
        .dc_ack   (dc_ack),
        .dc_rdata (dc_rdata)
    );

    ////////////////////
    // Reporting
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_word(input string name, input addr_t addr,
                              input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s = %h, expected %h (addr %h)",
                                $time, name, got, exp, addr));
        end
    endtask

    function automatic word_t merge_bytes(input word_t old, input word_t wdata, input ben_t ben);
        word_t result;
        result = old;
        for (int b = 0; b < `BYTES_PER_WORD; b++) begin
            if (ben[b]) result[8*b +: 8] = wdata[8*b +: 8];
        end
        return result;
    endfunction

    ////////////////////
    // Port exchanges
    ////////////////////

    task automatic fetch_word(input addr_t addr, output word_t data);
        int waited;
        @(posedge clk);
        #1;
        ic_addr = addr;
        ic_req  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!ic_ack) begin
            if (waited == TIMEOUT_CYCLES) abort_run("instruction fetch never completed");
            waited++;
            @(negedge clk);
        end
        data = ic_rdata;    // Held while ack is high
        @(posedge clk);
        #1;
        ic_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (ic_ack) begin
            if (waited == TIMEOUT_CYCLES) abort_run("ic_ack stayed high after req dropped");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic access_data(input logic we, input addr_t addr, input word_t wdata,
                               input ben_t ben, output word_t rdata);
        int waited;
        @(posedge clk);
        #1;
        dc_we    = we;
        dc_addr  = addr;
        dc_wdata = wdata;
        dc_ben   = ben;
        dc_req   = 1'b1;
        waited   = 0;
        @(negedge clk);
        while (!dc_ack) begin
            if (waited == TIMEOUT_CYCLES) abort_run("data access never completed");
            waited++;
            @(negedge clk);
        end
        rdata = dc_rdata;
        @(posedge clk);
        #1;
        dc_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (dc_ack) begin
            if (waited == TIMEOUT_CYCLES) abort_run("dc_ack stayed high after req dropped");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic compare_fetch(input addr_t addr);
        word_t exp;
        word_t got;
        exp = model[addr];
        fetch_word(addr, got);
        check_word("ic_rdata", addr, got, exp);
    endtask

    task automatic track_data_op(input logic we, input addr_t addr,
                                 input word_t wdata, input ben_t ben);
        word_t got;
        access_data(we, addr, wdata, ben, got);
        if (we) begin
            model[addr] = merge_bytes(model[addr], wdata, ben);
        end else begin
            check_word("dc_rdata", addr, got, model[addr]);
        end
    endtask

    // One access on each port in parallel after separate gaps
    task automatic issue_pair(input addr_t ia, input addr_t da, input logic we,
                              input word_t wd, input ben_t ben, input int ig, input int dg);
        fork
            begin
                repeat (ig) @(posedge clk);
                compare_fetch(ia);
            end
            begin
                repeat (dg) @(posedge clk);
                track_data_op(we, da, wd, ben);
            end
        join
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        int    waited;
        int    done;
        int    mode;
        addr_t ia, da;
        logic  we;

        ic_req   = 1'b0;
        ic_addr  = '0;
        dc_req   = 1'b0;
        dc_we    = 1'b0;
        dc_addr  = '0;
        dc_wdata = '0;
        dc_ben   = '0;
        void'($urandom(32'hf5e0));

        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited == 20) abort_run("reset never released");
            waited++;
            @(posedge clk);
        end
        @(negedge clk);
        if (ic_ack !== 1'b0) begin
            abort_run($sformatf("mismatch at %0t: ic_ack = %b, expected 0", $time, ic_ack));
        end
        if (dc_ack !== 1'b0) begin
            abort_run($sformatf("mismatch at %0t: dc_ack = %b, expected 0", $time, dc_ack));
        end

        // Fill all of memory, then read it back
        for (int a = 0; a < `RAM_WORDS; a++) track_data_op(1'b1, addr_t'(a), $urandom, '1);
        for (int a = 0; a < `RAM_WORDS; a++) track_data_op(1'b0, addr_t'(a), '0, '0);

        // Partial writes
        for (int i = 0; i < 200; i++) begin
            track_data_op(1'b1, addr_t'($urandom), $urandom, ben_t'($urandom));
        end
        for (int i = 0; i < 200; i++) track_data_op(1'b0, addr_t'($urandom), '0, '0);

        // Odd rounds evict the stored line from the data cache before the fetch
        for (int i = 0; i < 40; i++) begin
            ia = addr_t'($urandom);
            track_data_op(1'b1, ia, $urandom, '1);
            if (i % 2 == 1) begin
                track_data_op(1'b0, ia ^ addr_t'(1 << (`BEAT_BITS + `INDEX_BITS)), '0, '0);
            end
            compare_fetch(ia);
        end

        for (int i = 0; i < 100; i++) begin
            ia = addr_t'($urandom);
            da = addr_t'($urandom);
            we = (da != ia) && $urandom_range(1);   // No store to the word being fetched
            issue_pair(ia, da, we, $urandom, ben_t'($urandom), 0, 0);
        end

        done = 0;
        while (done < MIX_ACCESSES) begin
            mode = $urandom_range(2);
            ia   = addr_t'($urandom);
            da   = addr_t'($urandom);
            we   = $urandom_range(1);
            if (mode == 0) begin
                repeat ($urandom_range(3)) @(posedge clk);
                compare_fetch(ia);
                done += 1;
            end else if (mode == 1) begin
                repeat ($urandom_range(3)) @(posedge clk);
                track_data_op(we, da, $urandom, ben_t'($urandom));
                done += 1;
            end else begin
                if (da == ia) we = 1'b0;
                issue_pair(ia, da, we, $urandom, ben_t'($urandom),
                           $urandom_range(3), $urandom_range(3));
                done += 2;
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/mem_pkg.sv
common/cache_pkg.sv
cache/cache_array.sv
cache/cache_control.sv
design/line_ram.sv
design/cache_top.sv
dv/clk_gen.sv
dv/tb_cache.sv
